// File: include/stream_defs.svh
`ifndef STREAM_DEFS_SVH
`define STREAM_DEFS_SVH

// width of one stream word
`define STREAM_DATA_W 32

// last-word index of a frame, word count minus one
`define STREAM_LEN_W 5

// data FIFO depth as log2, 32 words
`define DATA_FIFO_AW 5

// length FIFO depth as log2, 4 frames
`define LEN_FIFO_AW 2

`endif

// File: src/stream_pkg.sv
`include "stream_defs.svh"

package stream_pkg;

   // one stream word
   typedef logic [`STREAM_DATA_W-1:0] data_t;

   // index of the last word in a frame
   typedef logic [`STREAM_LEN_W-1:0] len_t;

endpackage

// File: src/fifo_pkg.sv
`include "stream_defs.svh"

package fifo_pkg;

   // data FIFO occupancy, 0 up to full depth
   typedef logic [`DATA_FIFO_AW:0] data_level_t;

   // length FIFO occupancy
   typedef logic [`LEN_FIFO_AW:0] len_level_t;

endpackage

// File: src/sync_fifo.sv
module sync_fifo #(
   parameter type T  = logic,
   parameter int  AW = 4
) (
   input  logic        clk_i,
   input  logic        reset_i,
   input  logic        wr_i,
   input  T            wdata_i,
   output logic        full_o,
   input  logic        rd_i,
   output T            rdata_o,
   output logic        empty_o,
   output logic [AW:0] level_o
);

   localparam int DEPTH = 2 ** AW;

   T              mem [DEPTH];
   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [AW:0]   count;
   logic          wr_en;
   logic          rd_en;

   // overflow and underflow are ignored
   assign wr_en = wr_i & ~full_o;
   assign rd_en = rd_i & ~empty_o;

   assign full_o  = (count == DEPTH[AW:0]);
   assign empty_o = (count == '0);
   assign level_o = count;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         count <= '0;
      end else begin
         case ({wr_en, rd_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // storage
   always_ff @(posedge clk_i) begin
      if (wr_en) begin
         mem[wr_ptr] <= wdata_i;
      end
   end

   // read data valid the cycle after rd_i
   always_ff @(posedge clk_i) begin
      if (rd_en) begin
         rdata_o <= mem[rd_ptr];
      end
   end

endmodule

// File: src/axis2fifo.sv
module axis2fifo (
   input  logic              clk_i,
   input  logic              reset_i,
   input  logic              en_i,

   // stream input
   input  logic              s_axis_tvalid_i,
   input  stream_pkg::data_t s_axis_tdata_i,
   input  logic              s_axis_tlast_i,
   output logic              s_axis_tready_o,

   // data FIFO write side
   input  logic              data_full_i,
   output logic              data_wr_o,
   output stream_pkg::data_t data_wdata_o,

   // length FIFO write side
   input  logic              len_full_i,
   output logic              len_wr_o,
   output stream_pkg::len_t  len_wdata_o
);

   logic             accept;
   stream_pkg::len_t word_idx;

   // room needed in both FIFOs, a tlast word writes both
   assign s_axis_tready_o = en_i & ~data_full_i & ~len_full_i;
   assign accept          = s_axis_tvalid_i & s_axis_tready_o;

   assign data_wr_o    = accept;
   assign data_wdata_o = s_axis_tdata_i;

   assign len_wr_o    = accept & s_axis_tlast_i;
   assign len_wdata_o = word_idx;

   // index of the next word within the current frame
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         word_idx <= '0;
      end else if (accept) begin
         if (s_axis_tlast_i) begin
            word_idx <= '0;
         end else begin
            word_idx <= word_idx + 1'b1;
         end
      end
   end

endmodule

// File: src/fifo2axis.sv
module fifo2axis (
   input  logic              clk_i,
   input  logic              reset_i,
   input  logic              en_i,

   // data FIFO read side
   input  logic              data_empty_i,
   output logic              data_rd_o,
   input  stream_pkg::data_t data_rdata_i,

   // length FIFO read side
   input  logic              len_empty_i,
   output logic              len_rd_o,
   input  stream_pkg::len_t  len_i,

   // stream output
   output logic              m_axis_tvalid_o,
   output stream_pkg::data_t m_axis_tdata_o,
   output logic              m_axis_tlast_o,
   input  logic              m_axis_tready_i
);

   logic             pipe_en;
   logic             valid_int;
   logic             last_int;
   logic             len_vld;
   logic             frame_read;
   logic             last_done;
   logic             last_rd;
   stream_pkg::len_t rd_cnt;

   // output register free or draining this cycle
   assign pipe_en = en_i & (m_axis_tready_i | ~m_axis_tvalid_o);

   // len_i holds the head frame length once len_vld is set
   assign data_rd_o = pipe_en & ~data_empty_i & len_vld & ~frame_read;
   assign last_rd   = data_rd_o & (rd_cnt == len_i);

   assign last_done = en_i & m_axis_tvalid_o & m_axis_tready_i & m_axis_tlast_o;

   // fetch the next length when idle or when the frame leaves
   assign len_rd_o = en_i & ~len_empty_i & (~len_vld | last_done);

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         len_vld <= 1'b0;
      end else if (len_rd_o) begin
         len_vld <= 1'b1;
      end else if (last_done) begin
         len_vld <= 1'b0;
      end
   end

   // stop reading once the whole frame is out of the FIFO
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         frame_read <= 1'b0;
      end else if (last_done) begin
         frame_read <= 1'b0;
      end else if (last_rd) begin
         frame_read <= 1'b1;
      end
   end

   // words read in the current frame
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         rd_cnt <= '0;
      end else if (last_done) begin
         rd_cnt <= '0;
      end else if (data_rd_o) begin
         rd_cnt <= rd_cnt + 1'b1;
      end
   end

   // valid stage, FIFO read data arrives alongside
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         valid_int <= 1'b0;
         last_int  <= 1'b0;
      end else if (pipe_en) begin
         valid_int <= data_rd_o;
         last_int  <= last_rd;
      end
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         m_axis_tvalid_o <= 1'b0;
         m_axis_tlast_o  <= 1'b0;
      end else if (pipe_en) begin
         m_axis_tvalid_o <= valid_int;
         m_axis_tlast_o  <= last_int;
      end
   end

   always_ff @(posedge clk_i) begin
      if (pipe_en) begin
         m_axis_tdata_o <= data_rdata_i;
      end
   end

endmodule

// File: src/stream_buffer.sv
`include "stream_defs.svh"

module stream_buffer (
   input  logic                  clk_i,
   input  logic                  reset_i,
   input  logic                  en_i,

   input  logic                  s_axis_tvalid_i,
   input  stream_pkg::data_t     s_axis_tdata_i,
   input  logic                  s_axis_tlast_i,
   output logic                  s_axis_tready_o,

   output logic                  m_axis_tvalid_o,
   output stream_pkg::data_t     m_axis_tdata_o,
   output logic                  m_axis_tlast_o,
   input  logic                  m_axis_tready_i,

   output fifo_pkg::data_level_t data_level_o
);

   logic              data_wr;
   logic              data_rd;
   logic              data_full;
   logic              data_empty;
   stream_pkg::data_t data_wdata;
   stream_pkg::data_t data_rdata;

   logic              len_wr;
   logic              len_rd;
   logic              len_full;
   logic              len_empty;
   stream_pkg::len_t  len_wdata;
   stream_pkg::len_t  len_rdata;

   axis2fifo in_conv (
      .clk_i          (clk_i),
      .reset_i        (reset_i),
      .en_i           (en_i),
      .s_axis_tvalid_i(s_axis_tvalid_i),
      .s_axis_tdata_i (s_axis_tdata_i),
      .s_axis_tlast_i (s_axis_tlast_i),
      .s_axis_tready_o(s_axis_tready_o),
      .data_full_i    (data_full),
      .data_wr_o      (data_wr),
      .data_wdata_o   (data_wdata),
      .len_full_i     (len_full),
      .len_wr_o       (len_wr),
      .len_wdata_o    (len_wdata)
   );

   // frame words
   sync_fifo #(
      .T (stream_pkg::data_t),
      .AW(`DATA_FIFO_AW)
   ) data_fifo (
      .clk_i  (clk_i),
      .reset_i(reset_i),
      .wr_i   (data_wr),
      .wdata_i(data_wdata),
      .full_o (data_full),
      .rd_i   (data_rd),
      .rdata_o(data_rdata),
      .empty_o(data_empty),
      .level_o(data_level_o)
   );

   // one last-word index per complete frame
   sync_fifo #(
      .T (stream_pkg::len_t),
      .AW(`LEN_FIFO_AW)
   ) len_fifo (
      .clk_i  (clk_i),
      .reset_i(reset_i),
      .wr_i   (len_wr),
      .wdata_i(len_wdata),
      .full_o (len_full),
      .rd_i   (len_rd),
      .rdata_o(len_rdata),
      .empty_o(len_empty),
      .level_o()
   );

   fifo2axis out_conv (
      .clk_i          (clk_i),
      .reset_i        (reset_i),
      .en_i           (en_i),
      .data_empty_i   (data_empty),
      .data_rd_o      (data_rd),
      .data_rdata_i   (data_rdata),
      .len_empty_i    (len_empty),
      .len_rd_o       (len_rd),
      .len_i          (len_rdata),
      .m_axis_tvalid_o(m_axis_tvalid_o),
      .m_axis_tdata_o (m_axis_tdata_o),
      .m_axis_tlast_o (m_axis_tlast_o),
      .m_axis_tready_i(m_axis_tready_i)
   );

endmodule

// File: tb/clk_gen.sv
module clk_gen #(
   parameter int PERIOD_NS = 4
) (
   output logic clk_o
);
   timeunit 1ns;
   timeprecision 1ps;

   initial begin
      clk_o = 1'b0;
      forever begin
         #(PERIOD_NS / 2.0) clk_o = ~clk_o;
      end
   end

endmodule

// File: tb/stream_buffer_tb.sv
`include "stream_defs.svh"

module stream_buffer_tb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int DEPTH = 1 << `DATA_FIFO_AW;
   // words held by the output valid stage and output register
   localparam int PIPE_WORDS = 2;
   localparam int MAX_WORDS = 5 + 6 * 16 + 5 * 16 + DEPTH + PIPE_WORDS + 10;
   // 20 ns per word, margin covers reset and the stall phases
   localparam int WATCHDOG_NS = MAX_WORDS * 20 + 2000;

   logic                      clk;
   logic                      reset;
   logic                      en;
   logic                      s_tvalid;
   logic [`STREAM_DATA_W-1:0] s_tdata;
   logic                      s_tlast;
   logic                      s_tready;
   logic                      m_tvalid;
   logic [`STREAM_DATA_W-1:0] m_tdata;
   logic                      m_tlast;
   logic                      m_tready;
   logic [`DATA_FIFO_AW:0]    level;

   logic [`STREAM_DATA_W-1:0] stim_data [$];
   logic                      stim_last [$];
   logic [`STREAM_DATA_W-1:0] exp_data [$];
   logic                      exp_last [$];
   logic [31:0]               rng_state;
   string                     test_name;
   int                        errors;
   int                        errors_at_start;
   int                        tests_failed;
   logic                      bp_done;

   clk_gen clock (.clk_o(clk));

   stream_buffer UUT (
      .clk_i          (clk),
      .reset_i        (reset),
      .en_i           (en),
      .s_axis_tvalid_i(s_tvalid),
      .s_axis_tdata_i (s_tdata),
      .s_axis_tlast_i (s_tlast),
      .s_axis_tready_o(s_tready),
      .m_axis_tvalid_o(m_tvalid),
      .m_axis_tdata_o (m_tdata),
      .m_axis_tlast_o (m_tlast),
      .m_axis_tready_i(m_tready),
      .data_level_o   (level)
   );

   function automatic logic [31:0] xorshift32();
      logic [31:0] x;
      x = rng_state;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      rng_state = x;
      return x;
   endfunction

   // frame length 1 to 16
   function automatic int rand_len();
      logic [31:0] r;
      r = xorshift32();
      return 1 + int'(r[3:0]);
   endfunction

   task automatic check_eq(input string what, input logic [31:0] expected,
                           input logic [31:0] actual);
      assert (actual === expected) else begin
         $display("Mismatch in %s, %s: expected %0h, actual %0h",
                  test_name, what, expected, actual);
         errors++;
      end
   endtask

   // queue a frame for the input and the reference model
   task automatic push_frame(input int len);
      logic [31:0] word;
      for (int i = 0; i < len; i++) begin
         word = xorshift32();
         stim_data.push_back(word);
         stim_last.push_back(i == len - 1);
         exp_data.push_back(word);
         exp_last.push_back(i == len - 1);
      end
   endtask

   task automatic drive_words(input int count);
      for (int n = 0; n < count; n++) begin
         @(negedge clk);
         s_tvalid = 1'b1;
         s_tdata  = stim_data.pop_front();
         s_tlast  = stim_last.pop_front();
         @(posedge clk);
         while (s_tready !== 1'b1) begin
            @(posedge clk);
         end
      end
      @(negedge clk);
      s_tvalid = 1'b0;
      s_tlast  = 1'b0;
   endtask

   task automatic wait_drain(input int max_cycles);
      int cycles;
      cycles = 0;
      while (exp_data.size() > 0 && cycles < max_cycles) begin
         @(negedge clk);
         cycles++;
      end
      assert (exp_data.size() == 0) else begin
         $display("Error: %s timed out with %0d output words still missing",
                  test_name, exp_data.size());
         errors++;
         exp_data.delete();
         exp_last.delete();
      end
   endtask

   task automatic end_test();
      if (errors == errors_at_start) begin
         $display("test %s: ok", test_name);
      end else begin
         tests_failed++;
         $display("test %s: %0d errors", test_name, errors - errors_at_start);
      end
   endtask

   // output side of the reference model, no transfer while disabled
   always @(posedge clk) begin
      if (!reset && en && m_tvalid && m_tready) begin
         assert (exp_data.size() > 0) else begin
            $display("Error: %s got an output word with no frame pending", test_name);
            errors++;
         end
         if (exp_data.size() > 0) begin
            check_eq("tdata", exp_data.pop_front(), m_tdata);
            check_eq("tlast", 32'(exp_last.pop_front()), 32'(m_tlast));
         end
      end
   end

   task automatic test_single_frame();
      test_name = "single_frame";
      errors_at_start = errors;
      m_tready = 1'b1;
      push_frame(5);
      drive_words(5);
      wait_drain(50);
      end_test();
   endtask

   task automatic test_back_to_back();
      test_name = "back_to_back";
      errors_at_start = errors;
      m_tready = 1'b1;
      for (int f = 0; f < 6; f++) begin
         push_frame(rand_len());
      end
      drive_words(stim_data.size());
      wait_drain(200);
      end_test();
   endtask

   task automatic test_backpressure();
      int          words;
      logic [31:0] r;
      test_name = "backpressure";
      errors_at_start = errors;
      for (int f = 0; f < 5; f++) begin
         push_frame(rand_len());
      end
      words = stim_data.size();
      bp_done = 1'b0;
      fork
         begin
            drive_words(words);
            wait_drain(words * 8);
            bp_done = 1'b1;
         end
         // random stalls on the output
         while (!bp_done) begin
            @(negedge clk);
            r = xorshift32();
            m_tready = r[0];
         end
      join
      m_tready = 1'b1;
      end_test();
   endtask

   task automatic test_fill_drain();
      test_name = "fill_drain";
      errors_at_start = errors;
      m_tready = 1'b0;
      for (int f = 0; f < 4; f++) begin
         push_frame(8);
      end
      // refills what the stalled output pipeline took out
      push_frame(PIPE_WORDS);
      drive_words(DEPTH + PIPE_WORDS);
      repeat (8) begin
         @(negedge clk);
         check_eq("data_level_o", DEPTH, 32'(level));
         check_eq("s_axis_tready_o", 0, 32'(s_tready));
      end
      m_tready = 1'b1;
      wait_drain(4 * DEPTH);
      @(negedge clk);
      check_eq("data_level_o", 0, 32'(level));
      end_test();
   endtask

   task automatic test_enable();
      logic [`STREAM_DATA_W-1:0] held_data;
      logic                      held_last;
      logic [`DATA_FIFO_AW:0]    held_level;
      int                        cycles;
      test_name = "enable";
      errors_at_start = errors;
      m_tready = 1'b0;
      push_frame(4);
      push_frame(6);
      drive_words(4);
      cycles = 0;
      while (!m_tvalid && cycles < 20) begin
         @(negedge clk);
         cycles++;
      end
      assert (m_tvalid) else begin
         $display("Error: %s saw no output word for a complete frame", test_name);
         errors++;
      end
      drive_words(3);
      // frozen with a word offered on the input and the output ready
      en = 1'b0;
      m_tready = 1'b1;
      s_tvalid = 1'b1;
      s_tdata = stim_data[0];
      s_tlast = stim_last[0];
      held_data = m_tdata;
      held_last = m_tlast;
      held_level = level;
      repeat (10) begin
         @(negedge clk);
         check_eq("s_axis_tready_o", 0, 32'(s_tready));
         check_eq("m_axis_tvalid_o", 1, 32'(m_tvalid));
         check_eq("m_axis_tdata_o", held_data, m_tdata);
         check_eq("m_axis_tlast_o", 32'(held_last), 32'(m_tlast));
         check_eq("data_level_o", 32'(held_level), 32'(level));
      end
      en = 1'b1;
      s_tvalid = 1'b0;
      drive_words(3);
      wait_drain(100);
      end_test();
   endtask

   initial begin
      reset = 1'b1;
      en = 1'b0;
      s_tvalid = 1'b0;
      s_tdata = '0;
      s_tlast = 1'b0;
      m_tready = 1'b0;
      rng_state = 32'd45;
      errors = 0;
      tests_failed = 0;
      test_name = "reset";
      errors_at_start = 0;
      repeat (10) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      // en still low, so the input stays closed
      check_eq("s_axis_tready_o", 0, 32'(s_tready));
      check_eq("m_axis_tvalid_o", 0, 32'(m_tvalid));
      check_eq("m_axis_tlast_o", 0, 32'(m_tlast));
      check_eq("data_level_o", 0, 32'(level));
      end_test();
      en = 1'b1;
      test_single_frame();
      test_back_to_back();
      test_backpressure();
      test_fill_drain();
      test_enable();
      $display("%0d of 6 tests failed, %0d errors in total", tests_failed, errors);
      if (errors == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("Error: watchdog expired after %0d ns, the run stopped moving", WATCHDOG_NS);
      $display("Regression failed");
      $finish;
   end

endmodule

// File: verilog.f
+incdir+include
src/stream_pkg.sv
src/fifo_pkg.sv
src/sync_fifo.sv
src/axis2fifo.sv
src/fifo2axis.sv
src/stream_buffer.sv
tb/clk_gen.sv
tb/stream_buffer_tb.sv

// File: run.sh
#!/bin/sh
# build with Verilator, run, and search the output for the pass message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f verilog.f --top-module stream_buffer_tb \
   -o stream_buffer_sim || exit 1
out=$(./obj_dir/stream_buffer_sim)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "Regression passed" && exit 0 || exit 1
